/* hw/set_ops_settings.svh */
`ifndef SET_OPS_SETTINGS_SVH
`define SET_OPS_SETTINGS_SVH

// Parallel response lanes
`define SET_OPS_LANES 4

// Data fields per packet, never fewer than the lanes
`define SET_OPS_FIELDS 8

// Field and metadata widths
`define SET_OPS_FIELD_W 32
`define SET_OPS_META_W 16

// Depth of the lane FIFOs and of the output FIFO
`define SET_OPS_FIFO_DEPTH 16

// Output FIFO occupancy that raises prog_full
`define SET_OPS_PROG_THRESH 8

`endif

/* hw/set_ops_pkg.sv */
`default_nettype none

`include "set_ops_settings.svh"

package set_ops_pkg;

    // --------------------
    // Plain vectors
    // --------------------
    typedef logic [`SET_OPS_FIELD_W-1:0] field_t;
    typedef logic [`SET_OPS_META_W-1:0]  meta_t;
    typedef logic [`SET_OPS_LANES-1:0]   lane_mask_t;

    // --------------------
    // Packets
    // --------------------
    typedef struct packed {
        meta_t                           meta;
        field_t [`SET_OPS_FIELDS-1:0]    field;
    } payload_t;

    typedef struct packed {
        logic     valid;
        payload_t payload;
    } packet_t;

    // Configuration word, mask bit 0 selects the base lane
    typedef struct packed {
        logic       valid;
        lane_mask_t mask;
    } set_ops_cfg_t;

    // Generator control FSM
    typedef enum logic [3:0] {
        GEN_RESET,
        GEN_IDLE,
        GEN_WAIT_CFG,
        GEN_SETUP_TRANS,
        GEN_SETUP,
        GEN_START_TRANS,
        GEN_START,
        GEN_BUSY,
        GEN_PAUSE_TRANS,
        GEN_PAUSE,
        GEN_BUSY_TRANS
    } gen_state_t;

endpackage : set_ops_pkg

`default_nettype wire

/* hw/set_ops_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "set_ops_settings.svh"

module set_ops_ctrl
    import set_ops_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  set_ops_cfg_t cfg_in,
    input  logic         cfg_ready,
    input  lane_mask_t   lane_empty,
    input  lane_mask_t   lane_ready,
    input  logic         out_prog_full,
    input  logic         out_empty,
    output lane_mask_t   lane_pop,
    output lane_mask_t   merge_mask,
    output logic         cfg_setup,
    output logic         done
);

    gen_state_t   state;
    gen_state_t   next_state;
    set_ops_cfg_t cfg_reg;
    lane_mask_t   mask_reg;
    lane_mask_t   lane_avail;
    logic         pop_en;
    logic         done_state;
    logic [1:0]   pop_hist;

    // --------------------
    // Configuration input
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_reg.valid <= 1'b0;
        end else begin
            cfg_reg.valid <= cfg_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        cfg_reg.mask <= cfg_in.mask;
    end

    // --------------------
    // Control FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= GEN_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            GEN_RESET:       next_state = GEN_IDLE;
            GEN_IDLE:        next_state = GEN_WAIT_CFG;
            GEN_WAIT_CFG: begin
                if (cfg_ready) begin
                    next_state = GEN_SETUP_TRANS;
                end
            end
            GEN_SETUP_TRANS: next_state = GEN_SETUP;
            GEN_SETUP: begin
                if (cfg_reg.valid) begin
                    next_state = GEN_START_TRANS;
                end
            end
            GEN_START_TRANS: next_state = GEN_START;
            GEN_START:       next_state = GEN_BUSY;
            GEN_BUSY: begin
                if (out_prog_full) begin
                    next_state = GEN_PAUSE_TRANS;
                end
            end
            GEN_PAUSE_TRANS: next_state = GEN_PAUSE;
            GEN_PAUSE: begin
                if (!out_prog_full) begin
                    next_state = GEN_BUSY_TRANS;
                end
            end
            GEN_BUSY_TRANS:  next_state = GEN_BUSY;
            default:         next_state = GEN_RESET;
        endcase
    end

    // Pops open one state before done may be reported
    always_comb begin
        pop_en     = 1'b0;
        done_state = 1'b0;
        case (state)
            GEN_START_TRANS: pop_en = 1'b1;
            GEN_START, GEN_BUSY, GEN_PAUSE_TRANS, GEN_PAUSE, GEN_BUSY_TRANS: begin
                pop_en     = 1'b1;
                done_state = 1'b1;
            end
            default:         pop_en = 1'b0;
        endcase
    end

    // Mask latched once per configuration
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mask_reg <= {`SET_OPS_LANES{1'b1}};
        end else if (state == GEN_SETUP && cfg_reg.valid) begin
            mask_reg <= cfg_reg.mask;
        end
    end

    assign merge_mask = mask_reg;

    // --------------------
    // Pop decision
    // --------------------
    assign lane_avail = ~lane_empty & lane_ready;

    // All masked lanes together or none
    always_comb begin
        if (pop_en && !out_prog_full && ((lane_avail & mask_reg) == mask_reg)) begin
            lane_pop = mask_reg;
        end else begin
            lane_pop = '0;
        end
    end

    // Recent pops are still between lane and output FIFO
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_setup <= 1'b0;
            pop_hist  <= '0;
            done      <= 1'b0;
        end else begin
            cfg_setup <= (state == GEN_SETUP_TRANS);
            pop_hist  <= {pop_hist[0], |lane_pop};
            done      <= done_state && (&lane_empty) && out_empty && !(|pop_hist);
        end
    end

    mask_base_lane_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (state == GEN_SETUP && cfg_reg.valid) |=> mask_reg[0]);

endmodule : set_ops_ctrl

`default_nettype wire

/* hw/set_ops_lane_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "set_ops_settings.svh"

module set_ops_lane_fifo
    import set_ops_pkg::*;
(
    input  logic    ap_clk,
    input  logic    areset_generator,
    input  packet_t response_in,
    input  logic    pop,
    output packet_t lane_out,
    output logic    empty
);

    localparam int DEPTH = `SET_OPS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    packet_t  in_reg;
    payload_t mem [DEPTH];
    payload_t rd_data;
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;
    logic     full;
    logic     wr_en;
    logic     rd_en;
    logic     rd_valid;

    // Input staging register
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_reg.valid <= 1'b0;
        end else begin
            in_reg.valid <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_reg.payload <= response_in.payload;
    end

    // --------------------
    // Circular buffer
    // --------------------
    assign full  = (count == count_t'(DEPTH));
    assign empty = (count == '0);
    assign wr_en = in_reg.valid && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_reg.payload;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            rd_valid <= rd_en;
        end
    end

    // Read data one cycle after the pop
    assign lane_out.valid   = rd_valid;
    assign lane_out.payload = rd_data;

    no_write_when_full_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        response_in.valid |=> !full);

    // Pops come from the controller and must never hit an empty lane
    pop_nonempty_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> !empty);

endmodule : set_ops_lane_fifo

`default_nettype wire

/* hw/set_ops_merge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "set_ops_settings.svh"

module set_ops_merge
    import set_ops_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_generator,
    input  packet_t    lane_out [`SET_OPS_LANES],
    input  lane_mask_t merge_mask,
    input  logic       request_ready,
    output packet_t    request_out,
    output logic       out_prog_full,
    output logic       out_empty
);

    localparam int DEPTH  = `SET_OPS_FIFO_DEPTH;
    localparam int THRESH = `SET_OPS_PROG_THRESH;
    localparam int PTR_W  = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    payload_t merged;
    packet_t  merge_reg;
    payload_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;
    logic     full;
    logic     wr_en;
    logic     rd_en;

    // --------------------
    // Field merge
    // --------------------

    // Lane 0 is the base packet
    always_comb begin
        merged = lane_out[0].payload;
        for (int j = 1; j < `SET_OPS_LANES; j++) begin
            if (merge_mask[j]) begin
                merged.field[j] = lane_out[j].payload.field[0];
            end
        end
    end

    // Masked lanes pop together, so lane 0 valid covers all of them
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            merge_reg.valid <= 1'b0;
        end else begin
            merge_reg.valid <= lane_out[0].valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        merge_reg.payload <= merged;
    end

    // --------------------
    // Output FIFO, FWFT
    // --------------------
    assign full          = (count == count_t'(DEPTH));
    assign out_empty     = (count == '0);
    assign out_prog_full = (count >= count_t'(THRESH));
    assign wr_en         = merge_reg.valid && !full;
    assign rd_en         = request_ready && !out_empty;

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= merge_reg.payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is always visible, registered on pop
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= rd_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_out.payload <= mem[rd_ptr];
    end

    no_write_when_full_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        lane_out[0].valid |=> !full);

endmodule : set_ops_merge

`default_nettype wire

/* hw/set_ops_gen_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "set_ops_settings.svh"

module set_ops_gen_top
    import set_ops_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  set_ops_cfg_t cfg_in,
    input  logic         cfg_ready,
    input  packet_t      response_in [`SET_OPS_LANES],
    input  lane_mask_t   lane_ready,
    input  logic         request_ready,
    output packet_t      request_out,
    output logic         cfg_setup,
    output logic         done
);

    lane_mask_t lane_pop;
    lane_mask_t lane_empty;
    lane_mask_t merge_mask;
    packet_t    lane_out [`SET_OPS_LANES];
    logic       out_prog_full;
    logic       out_empty;

    // --------------------
    // Control
    // --------------------
    set_ops_ctrl ctrl_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_in           (cfg_in),
        .cfg_ready        (cfg_ready),
        .lane_empty       (lane_empty),
        .lane_ready       (lane_ready),
        .out_prog_full    (out_prog_full),
        .out_empty        (out_empty),
        .lane_pop         (lane_pop),
        .merge_mask       (merge_mask),
        .cfg_setup        (cfg_setup),
        .done             (done)
    );

    // --------------------
    // Response lanes
    // --------------------
    generate
        for (genvar i = 0; i < `SET_OPS_LANES; i++) begin : gen_lane
            set_ops_lane_fifo lane_i (
                .ap_clk           (ap_clk),
                .areset_generator (areset_generator),
                .response_in      (response_in[i]),
                .pop              (lane_pop[i]),
                .lane_out         (lane_out[i]),
                .empty            (lane_empty[i])
            );
        end
    endgenerate

    // --------------------
    // Merge and output
    // --------------------
    set_ops_merge merge_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .lane_out         (lane_out),
        .merge_mask       (merge_mask),
        .request_ready    (request_ready),
        .request_out      (request_out),
        .out_prog_full    (out_prog_full),
        .out_empty        (out_empty)
    );

endmodule : set_ops_gen_top

`default_nettype wire

/* tb/tb_set_ops_tests.svh */
`ifndef TB_SET_OPS_TESTS_SVH
`define TB_SET_OPS_TESTS_SVH

// --------------------
// Stimulus
// --------------------
task automatic apply_reset();
    @(posedge ap_clk);
    areset_generator <= 1'b1;
    cfg_in           <= '0;
    cfg_ready        <= 1'b0;
    lane_ready       <= '1;
    request_ready    <= 1'b1;
    for (int i = 0; i < `SET_OPS_LANES; i++) begin
        response_in[i] <= '0;
    end
    exp_q.delete();
    repeat (8) @(posedge ap_clk);
    areset_generator <= 1'b0;
    @(negedge ap_clk);
    check_value("done", done, 1'b0);
    check_value("cfg_setup", cfg_setup, 1'b0);
    check_value("request_out.valid", request_out.valid, 1'b0);
endtask

// Setup pulse must last one cycle, done follows the mask
task automatic configure(input lane_mask_t mask);
    @(posedge ap_clk);
    cfg_ready <= 1'b1;
    wait_for_cfg_setup();
    @(negedge ap_clk);
    check_value("cfg_setup", cfg_setup, 1'b0);
    @(posedge ap_clk);
    cfg_ready <= 1'b0;
    cfg_in    <= '{valid: 1'b1, mask: mask};
    @(posedge ap_clk);
    cfg_in.valid <= 1'b0;
    cur_mask = mask;
    wait_for_done();
endtask

// One packet per cycle on every masked lane
task automatic send_packets(input int count);
    payload_t    pl [`SET_OPS_LANES];
    payload_t    expected;
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
        for (int i = 0; i < `SET_OPS_LANES; i++) begin
            r = next_rand();
            pl[i].meta = r[`SET_OPS_META_W-1:0];
            for (int f = 0; f < `SET_OPS_FIELDS; f++) begin
                pl[i].field[f] = next_rand();
            end
        end
        // Lane 0 is the base, masked lane j gives its field 0 to slot j
        expected = pl[0];
        for (int j = 1; j < `SET_OPS_LANES; j++) begin
            if (cur_mask[j]) expected.field[j] = pl[j].field[0];
        end
        exp_q.push_back(expected);
        @(posedge ap_clk);
        for (int i = 0; i < `SET_OPS_LANES; i++) begin
            response_in[i] <= '{valid: cur_mask[i], payload: pl[i]};
        end
    end
    @(posedge ap_clk);
    for (int i = 0; i < `SET_OPS_LANES; i++) begin
        response_in[i].valid <= 1'b0;
    end
endtask

// --------------------
// Directed tests
// --------------------
task automatic test_first_config();
    apply_reset();
    configure('1);
endtask

task automatic test_full_mask();
    send_packets(10);
    wait_for_drain();
    wait_for_done();
endtask

task automatic test_partial_mask();
    apply_reset();
    configure(lane_mask_t'(4'b0101));
    send_packets(10);
    wait_for_drain();
    wait_for_done();
endtask

// Lane 2 is masked, holding its ready low stalls every pop
task automatic test_gating();
    @(posedge ap_clk);
    lane_ready <= ~lane_mask_t'(4'b0100);
    send_packets(4);
    expect_quiet(40);
    check_value("done", done, 1'b0);
    @(posedge ap_clk);
    lane_ready <= '1;
    wait_for_drain();
    wait_for_done();
endtask

task automatic test_backpressure();
    @(posedge ap_clk);
    request_ready <= 1'b0;
    send_packets(`SET_OPS_PROG_THRESH + 4);
    expect_quiet(40);
    check_value("done", done, 1'b0);
    @(posedge ap_clk);
    request_ready <= 1'b1;
    wait_for_drain();
    wait_for_done();
endtask

`endif

/* tb/tb_set_ops_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "set_ops_settings.svh"

module tb_set_ops_gen
    import set_ops_pkg::*;
();

    localparam int CHK_W      = $bits(payload_t);
    localparam int WAIT_LIMIT = 400;

    logic         ap_clk = 1'b0;
    logic         areset_generator;
    set_ops_cfg_t cfg_in;
    logic         cfg_ready;
    packet_t      response_in [`SET_OPS_LANES];
    lane_mask_t   lane_ready;
    logic         request_ready;
    packet_t      request_out;
    logic         cfg_setup;
    logic         done;

    // Expected request payloads, oldest first
    payload_t     exp_q [$];
    lane_mask_t   cur_mask;
    logic [31:0]  rng_state = 32'hc3a5_9b43;

    always #50 ap_clk = ~ap_clk;

    set_ops_gen_top dut_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_in           (cfg_in),
        .cfg_ready        (cfg_ready),
        .response_in      (response_in),
        .lane_ready       (lane_ready),
        .request_ready    (request_ready),
        .request_out      (request_out),
        .cfg_setup        (cfg_setup),
        .done             (done)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_now(input string reason);
        $display("ERROR: %s", reason);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [CHK_W-1:0] got,
                               input logic [CHK_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // --------------------
    // Wait loops
    // --------------------
    task automatic wait_for_cfg_setup();
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (!cfg_setup) begin
            if (cycles == WAIT_LIMIT) fail_now("timeout waiting for the cfg_setup pulse");
            @(negedge ap_clk);
            cycles++;
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (!done) begin
            if (cycles == WAIT_LIMIT) fail_now("timeout waiting for done to rise");
            @(negedge ap_clk);
            cycles++;
        end
    endtask

    // Model queue empties as the monitor consumes requests
    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles == WAIT_LIMIT) fail_now("timeout waiting for requests to drain");
            @(posedge ap_clk);
            cycles++;
        end
    endtask

    // Request output must stay idle for the whole window
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            if (request_out.valid) fail_now("request_out valid while it should be held");
        end
    endtask

    // Every request compared against the model, in order
    always @(negedge ap_clk) begin : monitor
        payload_t expected;
        if (!areset_generator && request_out.valid) begin
            if (exp_q.size() == 0) begin
                fail_now("request_out carried a packet that was never sent");
            end else begin
                expected = exp_q.pop_front();
                check_value("request_out.payload", request_out.payload, expected);
            end
        end
    end

    initial begin
        areset_generator = 1'b1;
        cfg_in           = '0;
        cfg_ready        = 1'b0;
        lane_ready       = '1;
        request_ready    = 1'b1;
        cur_mask         = '1;
        for (int i = 0; i < `SET_OPS_LANES; i++) begin
            response_in[i] = '0;
        end

        test_first_config();
        test_full_mask();
        test_partial_mask();
        test_gating();
        test_backpressure();

        $display("all tests passed");
        $finish;
    end

    `include "tb_set_ops_tests.svh"

endmodule : tb_set_ops_gen

`default_nettype wire

/* set_ops_gen.f */
+incdir+hw
+incdir+tb
hw/set_ops_pkg.sv
hw/set_ops_ctrl.sv
hw/set_ops_lane_fifo.sv
hw/set_ops_merge.sv
hw/set_ops_gen_top.sv
tb/tb_set_ops_gen.sv
